// ==== collision/bullet_strike_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module bullet_strike_check import tank_arena_pkg::*; (
  input  mover_t     bullet,
  input  pos_t       enemy,
  input  wall_set_t  walls,
  input  wall_mask_t wall_absorbing,
  output wall_mask_t wall_hit,
  output logic       bullet_hit,
  output logic       tank_struck
);

  wall_mask_t reach;

  // next position reaches the facing edge, current one is not past it yet
  function automatic logic reaches(
    mover_t b,
    pos_t   box,
    coord_t w,
    coord_t h
  );
    coord_t box_r;
    coord_t box_b;
    coord_t tip_r;
    coord_t tip_b;
    logic   x_ovl;
    logic   y_ovl;
    box_r = box.x + w;
    box_b = box.y + h;
    tip_r = b.pos.x + BULLET_SIZE;
    tip_b = b.pos.y + BULLET_SIZE;
    x_ovl = spans_overlap(b.pos.x, BULLET_SIZE, box.x, w);
    y_ovl = spans_overlap(b.pos.y, BULLET_SIZE, box.y, h);
    case (b.dir)
      UP: begin
        return x_ovl && ((b.pos.y - BULLET_STEP) <= box_b) && (b.pos.y >= box_b);
      end
      RIGHT: begin
        return y_ovl && ((tip_r + BULLET_STEP) >= box.x) && (tip_r <= box.x);
      end
      LEFT: begin
        return y_ovl && ((b.pos.x - BULLET_STEP) <= box_r) && (b.pos.x >= box_r);
      end
      DOWN: begin
        return x_ovl && ((tip_b + BULLET_STEP) >= box.y) && (tip_b <= box.y);
      end
      default: begin
        return 1'b0;  // bullet not in flight
      end
    endcase
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_WALLS; i++) begin
      reach[i] = reaches(bullet, walls[i], WALL_W[i], WALL_H[i]) && wall_absorbing[i];
    end
  end

  // lowest index takes the hit
  assign wall_hit   = reach & (~reach + wall_mask_t'(1));
  assign bullet_hit = |wall_hit;

  // independent of any wall in the way
  assign tank_struck = reaches(bullet, enemy, TANK_SIZE, TANK_SIZE);

endmodule

`default_nettype wire

// ==== collision/collision_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module collision_unit import tank_arena_pkg::*; (
  input  logic                     Clk,
  input  logic                     Reset,
  input  wall_set_t                walls,
  input  mover_t                   tank1,
  input  mover_t                   tank2,
  input  mover_t                   bullet1,
  input  mover_t                   bullet2,
  output logic                     can_move1,
  output logic                     can_move2,
  output logic                     bullet_hit1,
  output logic                     bullet_hit2,
  output logic                     tank_struck1,  // by bullet 2
  output logic                     tank_struck2,  // by bullet 1
  output damage_t [NUM_WALLS-1:0]  wall_damage
);

  wall_mask_t wall_blocking;
  wall_mask_t wall_absorbing;
  wall_mask_t wall_hit1;
  wall_mask_t wall_hit2;

  tank_motion_check u_motion1 (
    .tank          (tank1),
    .walls         (walls),
    .wall_blocking (wall_blocking),
    .can_move      (can_move1)
  );

  tank_motion_check u_motion2 (
    .tank          (tank2),
    .walls         (walls),
    .wall_blocking (wall_blocking),
    .can_move      (can_move2)
  );

  // each bullet aims at the other player's tank
  bullet_strike_check u_strike1 (
    .bullet         (bullet1),
    .enemy          (tank2.pos),
    .walls          (walls),
    .wall_absorbing (wall_absorbing),
    .wall_hit       (wall_hit1),
    .bullet_hit     (bullet_hit1),
    .tank_struck    (tank_struck2)
  );

  bullet_strike_check u_strike2 (
    .bullet         (bullet2),
    .enemy          (tank1.pos),
    .walls          (walls),
    .wall_absorbing (wall_absorbing),
    .wall_hit       (wall_hit2),
    .bullet_hit     (bullet_hit2),
    .tank_struck    (tank_struck1)
  );

  wall_damage_ctrl u_damage (
    .Clk            (Clk),
    .Reset          (Reset),
    .wall_hit1      (wall_hit1),
    .wall_hit2      (wall_hit2),
    .wall_damage    (wall_damage),
    .wall_blocking  (wall_blocking),
    .wall_absorbing (wall_absorbing)
  );

endmodule

`default_nettype wire

// ==== collision/tank_motion_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module tank_motion_check import tank_arena_pkg::*; (
  input  mover_t     tank,
  input  wall_set_t  walls,
  input  wall_mask_t wall_blocking,
  output logic       can_move
);

  wall_mask_t contact;  // walls the next step would touch

  always_comb begin
    contact = '0;
    for (int i = 0; i < NUM_WALLS; i++) begin
      case (tank.dir)
        UP: begin
          contact[i] = ((tank.pos.y - TANK_STEP) == (walls[i].y + WALL_H[i])) &&
                       spans_overlap(tank.pos.x, TANK_SIZE, walls[i].x, WALL_W[i]);
        end
        RIGHT: begin
          contact[i] = ((tank.pos.x + TANK_SIZE + TANK_STEP) == walls[i].x) &&
                       spans_overlap(tank.pos.y, TANK_SIZE, walls[i].y, WALL_H[i]);
        end
        LEFT: begin
          contact[i] = ((tank.pos.x - TANK_STEP) == (walls[i].x + WALL_W[i])) &&
                       spans_overlap(tank.pos.y, TANK_SIZE, walls[i].y, WALL_H[i]);
        end
        DOWN: begin
          contact[i] = ((tank.pos.y + TANK_SIZE + TANK_STEP) == walls[i].y) &&
                       spans_overlap(tank.pos.x, TANK_SIZE, walls[i].x, WALL_W[i]);
        end
        default: begin
          contact[i] = 1'b0;  // standing still
        end
      endcase
    end
  end

  // worn walls no longer stop a tank
  assign can_move = ~|(contact & wall_blocking);

endmodule

`default_nettype wire

// ==== collision/wall_damage_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module wall_damage_ctrl import tank_arena_pkg::*; (
  input  logic                     Clk,
  input  logic                     Reset,
  input  wall_mask_t               wall_hit1,
  input  wall_mask_t               wall_hit2,
  output damage_t [NUM_WALLS-1:0]  wall_damage,
  output wall_mask_t               wall_blocking,
  output wall_mask_t               wall_absorbing
);

  wall_mask_t charged;

  assign charged = wall_hit1 | wall_hit2;  // two bullets on one wall still count once

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      wall_damage <= '0;
    end else begin
      for (int i = 0; i < NUM_WALLS; i++) begin
        if (charged[i] && wall_absorbing[i]) begin
          wall_damage[i] <= wall_damage[i] + damage_t'(1);  // saturates at WALL_HITS
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_WALLS; i++) begin
      wall_blocking[i]  = wall_damage[i] < WALL_BLOCK_LIMIT;
      wall_absorbing[i] = wall_damage[i] < WALL_HITS;
    end
  end

endmodule

`default_nettype wire

// ==== common/tank_arena_pkg.sv ====
`default_nettype none

package tank_arena_pkg;

  typedef logic [9:0] coord_t;

  localparam int NUM_WALLS = 4;

  // upper-left corner of a box
  typedef struct packed {
    coord_t x;
    coord_t y;
  } pos_t;

  typedef enum logic [2:0] {
    NONE  = 3'd0,
    UP    = 3'd1,
    RIGHT = 3'd2,
    LEFT  = 3'd3,
    DOWN  = 3'd4
  } dir_e;

  typedef struct packed {
    pos_t pos;
    dir_e dir;  // NONE on a bullet means not in flight
  } mover_t;

  typedef pos_t [NUM_WALLS-1:0] wall_set_t;
  typedef logic [2:0] damage_t;
  typedef logic [NUM_WALLS-1:0] wall_mask_t;

  localparam coord_t TANK_SIZE   = 10'd32;
  localparam coord_t BULLET_SIZE = 10'd8;
  localparam coord_t TANK_STEP   = 10'd1;
  localparam coord_t BULLET_STEP = 10'd5;

  localparam coord_t H_WALL_W = 10'd64;
  localparam coord_t H_WALL_H = 10'd32;
  localparam coord_t V_WALL_W = 10'd32;
  localparam coord_t V_WALL_H = 10'd64;

  // even walls lie flat, odd walls stand up
  localparam coord_t [NUM_WALLS-1:0] WALL_W = {V_WALL_W, H_WALL_W, V_WALL_W, H_WALL_W};
  localparam coord_t [NUM_WALLS-1:0] WALL_H = {V_WALL_H, H_WALL_H, V_WALL_H, H_WALL_H};

  localparam damage_t WALL_BLOCK_LIMIT = 3'd3;  // tanks drive through from here on
  localparam damage_t WALL_HITS        = 3'd4;  // bullets pass, counter holds

  // open intervals, so touching ends do not count
  function automatic logic spans_overlap(
    coord_t a_lo,
    coord_t a_len,
    coord_t b_lo,
    coord_t b_len
  );
    return ((a_lo + a_len) > b_lo) && (a_lo < (b_lo + b_len));
  endfunction

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+tests
common/tank_arena_pkg.sv
collision/tank_motion_check.sv
collision/bullet_strike_check.sv
collision/wall_damage_ctrl.sv
collision/collision_unit.sv
tests/collision_tb.sv

// ==== tests/collision_cases.svh ====
`ifndef COLLISION_CASES_SVH
`define COLLISION_CASES_SVH

typedef struct {
  wall_set_t  walls;
  mover_t     tank1;
  mover_t     tank2;
  mover_t     bullet1;
  mover_t     bullet2;
  logic       can_move1;
  logic       can_move2;
  wall_mask_t hit1;     // wall charged by bullet 1
  wall_mask_t hit2;
  logic       struck1;
  logic       struck2;
} case_row_t;

case_row_t rows[$];

function automatic mover_t make_mover(input int x, input int y, input dir_e dir);
  mover_t m;
  m.pos.x = coord_t'(x);
  m.pos.y = coord_t'(y);
  m.dir = dir;
  return m;
endfunction

// flat walls at y 100 and 300, upright walls at x 300
function automatic wall_set_t spread_walls();
  wall_set_t w;
  w[0] = '{x: 100, y: 100};
  w[1] = '{x: 300, y: 100};
  w[2] = '{x: 100, y: 300};
  w[3] = '{x: 300, y: 300};
  return w;
endfunction

// wall 1 moved to butt against the right end of wall 0
function automatic wall_set_t joined_walls();
  wall_set_t w;
  w = spread_walls();
  w[1] = '{x: 164, y: 100};
  return w;
endfunction

function automatic void add_case(input wall_set_t layout, input mover_t t1, input mover_t t2,
                                 input mover_t b1, input mover_t b2, input logic cm1,
                                 input logic cm2, input wall_mask_t h1, input wall_mask_t h2,
                                 input logic s1, input logic s2);
  case_row_t r;
  r.walls = layout;
  r.tank1 = t1;
  r.tank2 = t2;
  r.bullet1 = b1;
  r.bullet2 = b2;
  r.can_move1 = cm1;
  r.can_move2 = cm2;
  r.hit1 = h1;
  r.hit2 = h2;
  r.struck1 = s1;
  r.struck2 = s2;
  rows.push_back(r);
endfunction

task automatic build_cases();
  mover_t still1;
  mover_t still2;
  mover_t off;
  mover_t target1;
  mover_t target2;
  still1 = make_mover(450, 20, NONE);
  still2 = make_mover(500, 500, NONE);
  off = make_mover(0, 0, NONE);
  target1 = make_mover(200, 400, NONE);
  target2 = make_mover(400, 400, NONE);
  // tank blocking with fresh walls
  add_case(spread_walls(), make_mover(120, 133, UP), still2, off, off,
           1'b0, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), make_mover(120, 134, UP), still2, off, off,
           1'b1, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), make_mover(267, 110, RIGHT), still2, off, off,
           1'b0, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), make_mover(266, 110, RIGHT), still2, off, off,
           1'b1, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), make_mover(333, 110, LEFT), still2, off, off,
           1'b0, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), make_mover(120, 267, DOWN), still2, off, off,
           1'b0, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), make_mover(68, 267, DOWN), still2, off, off,  // corner only
           1'b1, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), still1, make_mover(310, 365, UP), off, off,
           1'b1, 1'b0, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), still1, make_mover(333, 310, LEFT), off, off,
           1'b1, 1'b0, 4'b0000, 4'b0000, 1'b0, 1'b0);
  // wall hits
  add_case(spread_walls(), still1, still2, make_mover(120, 135, UP), off,
           1'b1, 1'b1, 4'b0001, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), still1, still2, off, make_mover(290, 120, RIGHT),
           1'b1, 1'b1, 4'b0000, 4'b0010, 1'b0, 1'b0);
  add_case(spread_walls(), still1, still2, make_mover(334, 130, LEFT),
           make_mover(290, 120, RIGHT), 1'b1, 1'b1, 4'b0010, 4'b0010, 1'b0, 1'b0);
  add_case(joined_walls(), still1, still2, make_mover(160, 90, DOWN), off,
           1'b1, 1'b1, 4'b0001, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), still1, still2, make_mover(120, 135, UP), off,
           1'b1, 1'b1, 4'b0001, 4'b0000, 1'b0, 1'b0);
  // wall 0 worn down
  add_case(spread_walls(), make_mover(120, 133, UP), still2, make_mover(120, 135, UP), off,
           1'b1, 1'b1, 4'b0001, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), make_mover(120, 133, UP), still2, make_mover(120, 135, UP), off,
           1'b1, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  add_case(spread_walls(), make_mover(267, 110, RIGHT), still2, off, make_mover(120, 90, DOWN),
           1'b0, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b0);
  // strikes on parked tanks
  add_case(spread_walls(), target1, target2, make_mover(390, 410, RIGHT), off,
           1'b1, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b1);
  add_case(spread_walls(), target1, target2, off, make_mover(210, 434, UP),
           1'b1, 1'b1, 4'b0000, 4'b0000, 1'b1, 1'b0);
  add_case(spread_walls(), target1, target2, make_mover(395, 410, RIGHT),
           make_mover(235, 410, LEFT), 1'b1, 1'b1, 4'b0000, 4'b0000, 1'b1, 1'b0);
  add_case(spread_walls(), target1, target2, make_mover(410, 390, DOWN), off,
           1'b1, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b1);
  add_case(spread_walls(), target1, target2, make_mover(410, 434, UP),
           make_mover(210, 396, DOWN), 1'b1, 1'b1, 4'b0000, 4'b0000, 1'b0, 1'b1);
endtask

`endif

// ==== tests/collision_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module collision_tb import tank_arena_pkg::*; ();

  logic                    Clk;
  logic                    Reset;
  wall_set_t               walls;
  mover_t                  tank1;
  mover_t                  tank2;
  mover_t                  bullet1;
  mover_t                  bullet2;
  logic                    can_move1;
  logic                    can_move2;
  logic                    bullet_hit1;
  logic                    bullet_hit2;
  logic                    tank_struck1;
  logic                    tank_struck2;
  damage_t [NUM_WALLS-1:0] wall_damage;

  damage_t ref_damage [NUM_WALLS];  // expected counters after the next edge
  integer  seed;
  logic    cases_ready = 1'b0;

  `include "collision_cases.svh"

  collision_unit DUT (
    .Clk          (Clk),
    .Reset        (Reset),
    .walls        (walls),
    .tank1        (tank1),
    .tank2        (tank2),
    .bullet1      (bullet1),
    .bullet2      (bullet2),
    .can_move1    (can_move1),
    .can_move2    (can_move2),
    .bullet_hit1  (bullet_hit1),
    .bullet_hit2  (bullet_hit2),
    .tank_struck1 (tank_struck1),
    .tank_struck2 (tank_struck2),
    .wall_damage  (wall_damage)
  );

  always #2 Clk = ~Clk;

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic check_damage(input damage_t got, input damage_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Test failures found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic compare_all_damage(input string when);
    for (int w = 0; w < NUM_WALLS; w++) begin
      check_damage(wall_damage[w], ref_damage[w], $sformatf("wall %0d damage %s", w, when));
    end
  endtask

  // parked tanks and idle bullets anywhere on screen
  task automatic add_idle_rows(input int count);
    case_row_t r;
    for (int n = 0; n < count; n++) begin
      r.walls = spread_walls();
      r.tank1 = make_mover($random(seed), $random(seed), NONE);
      r.tank2 = make_mover($random(seed), $random(seed), NONE);
      r.bullet1 = make_mover($random(seed), $random(seed), NONE);
      r.bullet2 = make_mover($random(seed), $random(seed), NONE);
      r.can_move1 = 1'b1;
      r.can_move2 = 1'b1;
      r.hit1 = '0;
      r.hit2 = '0;
      r.struck1 = 1'b0;
      r.struck2 = 1'b0;
      rows.push_back(r);
    end
  endtask

  task automatic apply_row(input case_row_t r);
    walls = r.walls;
    tank1 = r.tank1;
    tank2 = r.tank2;
    bullet1 = r.bullet1;
    bullet2 = r.bullet2;
  endtask

  task automatic check_outputs(input case_row_t r, input int idx);
    check_flag(can_move1, r.can_move1, $sformatf("row %0d can_move1", idx));
    check_flag(can_move2, r.can_move2, $sformatf("row %0d can_move2", idx));
    check_flag(bullet_hit1, |r.hit1, $sformatf("row %0d bullet_hit1", idx));
    check_flag(bullet_hit2, |r.hit2, $sformatf("row %0d bullet_hit2", idx));
    check_flag(tank_struck1, r.struck1, $sformatf("row %0d tank_struck1", idx));
    check_flag(tank_struck2, r.struck2, $sformatf("row %0d tank_struck2", idx));
  endtask

  // one step per charged wall, held at the bullet limit
  task automatic update_damage_model(input case_row_t r);
    wall_mask_t charged;
    charged = r.hit1 | r.hit2;
    for (int w = 0; w < NUM_WALLS; w++) begin
      if (charged[w] && (ref_damage[w] < WALL_HITS)) begin
        ref_damage[w] = ref_damage[w] + damage_t'(1);
      end
    end
  endtask

  initial begin
    seed = 32'h15ca_6b12;
    Clk = 1'b0;
    Reset = 1'b1;
    walls = '0;
    tank1 = '0;
    tank2 = '0;
    bullet1 = '0;
    bullet2 = '0;
    for (int w = 0; w < NUM_WALLS; w++) begin
      ref_damage[w] = '0;
    end
    add_idle_rows(8);
    build_cases();
    cases_ready = 1'b1;
    repeat (10) @(posedge Clk);
    #1;
    Reset = 1'b0;
    compare_all_damage("after reset");
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge Clk);
      #1;
      compare_all_damage($sformatf("before row %0d", i));
      apply_row(rows[i]);
      #2;  // outputs settled, next edge still 1 ns away
      check_outputs(rows[i], i);
      update_damage_model(rows[i]);
    end
    @(posedge Clk);
    #1;
    compare_all_damage("at end");
    $display("All tests passed!");
    $finish;
  end

  initial begin
    int limit_ns;
    wait (cases_ready === 1'b1);
    limit_ns = (rows.size() + 20) * 2 * 4;
    #(limit_ns);
    $display("Simulation timed out after %0d ns before the table finished", limit_ns);
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
